//--- bench/platform_tb.sv
// Testbench for the platform renderer.
// Random level requests and game enables, a frame model and per-pixel checks.
`timescale 1ns/1ns
`default_nettype none

module platform_tb;

    localparam int FRAME_CYCLES    = int'(game_pkg::H_TOTAL) * int'(game_pkg::V_TOTAL);
    localparam int WATCHDOG_CYCLES = 6 * FRAME_CYCLES + 100000;  // Six frames plus margin.

    logic             clk;
    logic             rst      = 1'b1;
    logic             game_en  = 1'b1;
    logic             lvl_req  = 1'b0;
    game_pkg::level_e lvl_code = game_pkg::LEVEL_EMPTY;
    logic             lvl_ack;
    logic [10:0]      hcount;
    logic [10:0]      vcount;
    logic             hsync;
    logic             vsync;
    logic [11:0]      rgb;

    int               seed = 31092;
    int               errors = 0;
    int               pixels_checked = 0;
    int               overlap_count = 0;
    int               frame_idx = -1;
    logic             checking = 1'b0;
    game_pkg::level_e model_level = game_pkg::LEVEL_EMPTY;
    game_pkg::level_e pending_level = game_pkg::LEVEL_EMPTY;
    logic             pending_valid = 1'b0;

    platform_top platform_top_i (
        .clk, .rst, .game_en, .lvl_req, .lvl_code, .lvl_ack,
        .hcount, .vcount, .hsync, .vsync, .rgb
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("Timeout: the run did not reach its last frame in time");
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic report_mismatch(input string test, input int expected, input int actual);
        errors++;
        $display("FAILED %s: expected 0x%0h, actual 0x%0h", test, expected, actual);
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("ERROR: %s", what);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model of one output pixel.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [11:0] pixel_color(input int h, input int v,
                                                input game_pkg::level_e level,
                                                input logic en, output logic overlap);
        logic [3:0]  rmask;
        logic [3:0]  lmask;
        logic        ramp_found;
        logic        ledge_found;
        logic [11:0] ramp_c;
        logic [11:0] ledge_c;
        int          left;
        int          top;
        int          vs;

        rmask       = game_pkg::LEVEL_RAMP_MASK[level];
        lmask       = game_pkg::LEVEL_LEDGE_MASK[level];
        ramp_found  = 1'b0;
        ledge_found = 1'b0;
        ramp_c      = '0;
        ledge_c     = '0;
        overlap     = 1'b0;
        // The first ramp that covers the pixel decides its texture.
        for (int r = 0; r < game_pkg::RAMP_COUNT; r++) begin
            for (int i = 0; i < game_pkg::RAMP_STEPS[r]; i++) begin
                left = int'(game_pkg::RAMP_HSTART[r]) + i * game_pkg::BLOCK_WIDTH;
                top  = game_pkg::RAMP_RISING[r] ?
                       int'(game_pkg::RAMP_VSTART[r]) - i * game_pkg::STEP_OFFSET :
                       int'(game_pkg::RAMP_VSTART[r]) + i * game_pkg::STEP_OFFSET;
                if (!ramp_found && rmask[r] && h >= left && h < left + game_pkg::BLOCK_WIDTH &&
                    v >= top && v < top + game_pkg::BLOCK_HEIGHT) begin
                    ramp_found = 1'b1;
                    ramp_c = ((((h - left) >> 3) & 1) == (((v - top) >> 2) & 1)) ?
                             game_pkg::RAMP_COLOR_A : game_pkg::RAMP_COLOR_B;
                end
            end
        end
        for (int l = 0; l < game_pkg::LEDGE_COUNT; l++) begin
            vs = int'(game_pkg::LEDGE_VSTART[l]);
            if (!ledge_found && lmask[l] && h >= int'(game_pkg::LEDGE_HSTART[l]) &&
                h < int'(game_pkg::LEDGE_HEND[l]) &&
                v >= vs && v < vs + game_pkg::LEDGE_HEIGHT) begin
                ledge_found = 1'b1;
                ledge_c = (v == vs) ? {game_pkg::LEDGE_COLOR[11:8] >> 1,
                                       game_pkg::LEDGE_COLOR[7:4] >> 1,
                                       game_pkg::LEDGE_COLOR[3:0] >> 1} : game_pkg::LEDGE_COLOR;
            end
        end
        if (h >= int'(game_pkg::H_ACTIVE) || v >= int'(game_pkg::V_ACTIVE)) begin
            return game_pkg::BLANK_COLOR;
        end
        if (!en) begin
            return game_pkg::BG_COLOR;
        end
        overlap = ramp_found && ledge_found;
        if (ledge_found) begin
            return ledge_c;
        end
        return ramp_found ? ramp_c : game_pkg::BG_COLOR;
    endfunction

    // One four-phase handshake, started at a random point of the frame.
    task automatic request_level(input game_pkg::level_e code);
        int delay;
        int hold;
        int waited;

        delay = ($random(seed) & 32'h1FFFF) + 16;
        hold  = ($random(seed) & 7) + 1;
        repeat (delay) @(posedge clk);
        if (lvl_ack !== 1'b0) report_problem("lvl_ack was high before the request");
        lvl_code <= code;
        lvl_req  <= 1'b1;
        waited = 0;
        @(posedge clk);
        while (lvl_ack !== 1'b1 && waited < FRAME_CYCLES + 8) begin
            @(posedge clk);
            waited++;
        end
        if (lvl_ack !== 1'b1) report_problem("no lvl_ack within one frame of lvl_req");
        repeat (hold) begin
            @(posedge clk);
            if (lvl_ack !== 1'b1) report_problem("lvl_ack fell while lvl_req was high");
        end
        lvl_req <= 1'b0;
        repeat (2) @(posedge clk);  // Ack must be gone one cycle after req.
        if (lvl_ack !== 1'b0) report_problem("lvl_ack did not fall one cycle after lvl_req");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output monitor for level tracking, sync shape and pixels.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    int   prev_h = 1;
    int   prev_v = 0;
    logic prev_ack = 1'b0;
    logic prev_hs = 1'b1;
    logic prev_vs = 1'b1;
    int   hs_len = 0;
    int   vs_len = 0;
    int   line_count = 0;
    int   vs_falls = 0;

    always @(posedge clk) begin
        logic [11:0] exp_rgb;
        logic        exp_hs;
        logic        exp_vs;
        logic        both;
        int          h;
        int          v;
        int          pos;

        if (checking) begin
            h = int'(hcount);
            v = int'(vcount);
            // Output counts trail the timing counters by three clocks and checking
            // starts one clock after reset, so the first two samples hold the reset value.
            pos = (pixels_checked < 2) ? 0 : (pixels_checked - 2) % FRAME_CYCLES;
            if (h != pos % 800) report_mismatch("hcount", pos % 800, h);
            if (v != pos / 800) report_mismatch("vcount", pos / 800, v);
            if (lvl_ack && !prev_ack) begin
                if (!lvl_req) report_problem("lvl_ack rose while lvl_req was low");
                pending_level = lvl_code;
                pending_valid = 1'b1;
            end
            if (h == 0 && v == 0 && !(prev_h == 0 && prev_v == 0)) begin
                frame_idx++;
                if (pending_valid) begin
                    model_level   = pending_level;  // New level from this frame on.
                    pending_valid = 1'b0;
                end
            end
            // Game enable only moves in vertical blanking.
            // It is forced on for frame 1 and off for frame 3.
            if (h == 0 && v == 500) begin
                game_en <= (frame_idx + 1 == 1) ? 1'b1 : (frame_idx + 1 == 3) ? 1'b0 :
                           (($random(seed) & 3) != 0);
            end
            exp_hs = !(h >= 656 && h < 752);
            exp_vs = !(v >= 490 && v < 492);
            if (hsync !== exp_hs) report_mismatch("hsync", exp_hs, hsync);
            if (vsync !== exp_vs) report_mismatch("vsync", exp_vs, vsync);
            if (!hsync) begin
                hs_len++;
            end else if (hs_len != 0) begin
                if (hs_len != 96) report_mismatch("hsync pulse length", 96, hs_len);
                hs_len = 0;
            end
            if (!vsync) begin
                vs_len++;
            end else if (vs_len != 0) begin
                if (vs_len != 1600) report_mismatch("vsync pulse length", 1600, vs_len);
                vs_len = 0;
            end
            if (!hsync && prev_hs) line_count++;
            if (!vsync && prev_vs) begin
                if (vs_falls > 0 && line_count != 525) begin
                    report_mismatch("hsync pulses per frame", 525, line_count);
                end
                line_count = 0;
                vs_falls++;
            end
            exp_rgb = pixel_color(h, v, model_level, game_en, both);
            if (rgb !== exp_rgb) begin
                report_mismatch($sformatf("pixel (%0d,%0d)", h, v), exp_rgb, rgb);
            end
            pixels_checked++;
            if (both) overlap_count++;
            prev_h   = h;
            prev_v   = v;
            prev_ack = lvl_ack;
            prev_hs  = hsync;
            prev_vs  = vsync;
        end
    end

    initial begin
        game_pkg::level_e code;

        repeat (2) @(posedge clk);
        if (hsync !== 1'b1) report_mismatch("reset hsync", 1, hsync);
        if (vsync !== 1'b1) report_mismatch("reset vsync", 1, vsync);
        if (rgb !== 12'h000) report_mismatch("reset rgb", 0, rgb);
        if (lvl_ack !== 1'b0) report_mismatch("reset lvl_ack", 0, lvl_ack);
        if (hcount !== 11'd0) report_mismatch("reset hcount", 0, hcount);
        if (vcount !== 11'd0) report_mismatch("reset vcount", 0, vcount);
        rst <= 1'b0;
        @(posedge clk);
        checking <= 1'b1;
        // The first level has every ramp and ledge, so overlaps show up early.
        for (int k = 0; k < 5; k++) begin
            code = (k == 0) ? game_pkg::LEVEL_THREE : game_pkg::level_e'(2'($random(seed)));
            request_level(code);
        end
        while (frame_idx < 6) @(posedge clk);
        if (overlap_count == 0) report_problem("no pixel with a ledge over a ramp was checked");
        $display("Checks done: %0d errors, %0d pixels, %0d ledge over ramp pixels",
                 errors, pixels_checked, overlap_count);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/game_pkg.sv
// Shared definitions for the platform renderer.
// Holds the VGA timing, ramp and ledge geometry, colours and level tables.
`default_nettype none

package game_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // 640x480 timing, one pixel per clock.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [10:0] H_ACTIVE = 11'd640;
    localparam logic [10:0] H_FRONT  = 11'd16;
    localparam logic [10:0] H_SYNC   = 11'd96;
    localparam logic [10:0] H_TOTAL  = 11'd800;
    localparam logic [10:0] V_ACTIVE = 11'd480;
    localparam logic [10:0] V_FRONT  = 11'd10;
    localparam logic [10:0] V_SYNC   = 11'd2;
    localparam logic [10:0] V_TOTAL  = 11'd525;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Staircase geometry.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int RAMP_COUNT   = 4;
    localparam int MAX_STEPS    = 14;  // Longest ramp, bounds the step loop.
    localparam int BLOCK_WIDTH  = 32;
    localparam int BLOCK_HEIGHT = 16;
    localparam int STEP_OFFSET  = 16;

    localparam logic [10:0] RAMP_HSTART [RAMP_COUNT] = '{11'd64, 11'd0, 11'd192, 11'd480};
    localparam logic [10:0] RAMP_VSTART [RAMP_COUNT] = '{11'd400, 11'd120, 11'd460, 11'd64};
    localparam int          RAMP_STEPS  [RAMP_COUNT] = '{8, 14, 14, 4};
    localparam logic        RAMP_RISING [RAMP_COUNT] = '{1'b1, 1'b0, 1'b1, 1'b0};

    // Flat ledges, end column is exclusive.
    localparam int          LEDGE_COUNT  = 4;
    localparam logic [10:0] LEDGE_HSTART [LEDGE_COUNT] = '{11'd96, 11'd320, 11'd0, 11'd400};
    localparam logic [10:0] LEDGE_HEND   [LEDGE_COUNT] = '{11'd224, 11'd480, 11'd160, 11'd600};
    localparam logic [10:0] LEDGE_VSTART [LEDGE_COUNT] = '{11'd240, 11'd320, 11'd440, 11'd180};
    localparam int          LEDGE_HEIGHT = 8;

    // RGB444 colours.
    localparam logic [11:0] BG_COLOR     = 12'h136;
    localparam logic [11:0] BLANK_COLOR  = 12'h888;
    localparam logic [11:0] RAMP_COLOR_A = 12'hA62;
    localparam logic [11:0] RAMP_COLOR_B = 12'h741;
    localparam logic [11:0] LEDGE_COLOR  = 12'h4C4;

    typedef enum logic [1:0] {
        LEVEL_EMPTY,
        LEVEL_ONE,
        LEVEL_TWO,
        LEVEL_THREE
    } level_e;

    // Bit n enables ramp or ledge n, indexed by the level code.
    localparam logic [3:0] LEVEL_RAMP_MASK  [4] = '{4'b0000, 4'b0011, 4'b1100, 4'b1111};
    localparam logic [3:0] LEVEL_LEDGE_MASK [4] = '{4'b0000, 4'b0001, 4'b0110, 4'b1111};

    typedef enum logic [1:0] {
        IDLE,
        PENDING,
        ACKED
    } lvl_state_e;

    localparam int DRAW_LATENCY = 2;  // Counters to hit and colour, in clocks.

endpackage

`default_nettype wire

//--- hw/layer_mix.sv
// Layer mixer, delaying the timing to match the renderers.
// Picks blank, background, ledge or ramp colour and registers the result.
`timescale 1ns/1ns
`default_nettype none

module layer_mix (
    input  logic        clk,
    input  logic        rst,
    input  logic        game_en,
    input  logic [10:0] hcount,
    input  logic [10:0] vcount,
    input  logic        hsync,
    input  logic        vsync,
    input  logic        blank,
    input  logic        ramp_hit,
    input  logic        ledge_hit,
    input  logic [11:0] ramp_rgb,
    input  logic [11:0] ledge_rgb,
    output logic [10:0] out_hcount,
    output logic [10:0] out_vcount,
    output logic        out_hsync,
    output logic        out_vsync,
    output logic [11:0] rgb
);

    localparam int LAST = game_pkg::DRAW_LATENCY - 1;

    logic [10:0] hcount_d [game_pkg::DRAW_LATENCY];
    logic [10:0] vcount_d [game_pkg::DRAW_LATENCY];
    logic        hsync_d  [game_pkg::DRAW_LATENCY];
    logic        vsync_d  [game_pkg::DRAW_LATENCY];
    logic        blank_d  [game_pkg::DRAW_LATENCY];
    logic [11:0] rgb_nxt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Timing delay line, as deep as the renderers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < game_pkg::DRAW_LATENCY; i++) begin
                hcount_d[i] <= '0;
                vcount_d[i] <= '0;
                hsync_d[i]  <= 1'b1;  // Syncs idle high.
                vsync_d[i]  <= 1'b1;
                blank_d[i]  <= 1'b0;
            end
        end else begin
            hcount_d[0] <= hcount;
            vcount_d[0] <= vcount;
            hsync_d[0]  <= hsync;
            vsync_d[0]  <= vsync;
            blank_d[0]  <= blank;
            for (int i = 1; i < game_pkg::DRAW_LATENCY; i++) begin
                hcount_d[i] <= hcount_d[i-1];
                vcount_d[i] <= vcount_d[i-1];
                hsync_d[i]  <= hsync_d[i-1];
                vsync_d[i]  <= vsync_d[i-1];
                blank_d[i]  <= blank_d[i-1];
            end
        end
    end

    // Blanking first, then game enable, then ledge over ramp over background.
    always_comb begin
        if (blank_d[LAST]) begin
            rgb_nxt = game_pkg::BLANK_COLOR;
        end else if (!game_en) begin
            rgb_nxt = game_pkg::BG_COLOR;
        end else if (ledge_hit) begin
            rgb_nxt = ledge_rgb;
        end else if (ramp_hit) begin
            rgb_nxt = ramp_rgb;
        end else begin
            rgb_nxt = game_pkg::BG_COLOR;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_hcount <= '0;
            out_vcount <= '0;
            out_hsync  <= 1'b1;
            out_vsync  <= 1'b1;
            rgb        <= '0;
        end else begin
            out_hcount <= hcount_d[LAST];
            out_vcount <= vcount_d[LAST];
            out_hsync  <= hsync_d[LAST];
            out_vsync  <= vsync_d[LAST];
            rgb        <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

//--- hw/ledge_draw.sv
// Flat ledge renderer, with a darker top row as the ledge edge.
`timescale 1ns/1ns
`default_nettype none

module ledge_draw (
    input  logic        clk,
    input  logic        rst,
    input  logic [10:0] hcount,
    input  logic [10:0] vcount,
    input  logic [3:0]  ledge_mask,
    output logic        ledge_hit,
    output logic [11:0] ledge_rgb
);

    logic        hit_nxt;
    logic        edge_nxt;
    logic        s1_hit;
    logic        s1_edge;
    logic [11:0] edge_color;

    // Each RGB444 channel halved.
    assign edge_color = {1'b0, game_pkg::LEDGE_COLOR[11:9],
                         1'b0, game_pkg::LEDGE_COLOR[7:5],
                         1'b0, game_pkg::LEDGE_COLOR[3:1]};

    always_comb begin
        hit_nxt  = 1'b0;
        edge_nxt = 1'b0;
        for (int l = game_pkg::LEDGE_COUNT - 1; l >= 0; l--) begin
            if (ledge_mask[l] &&
                (hcount >= game_pkg::LEDGE_HSTART[l]) && (hcount < game_pkg::LEDGE_HEND[l]) &&
                (vcount >= game_pkg::LEDGE_VSTART[l]) &&
                (vcount < game_pkg::LEDGE_VSTART[l] + 11'(game_pkg::LEDGE_HEIGHT))) begin
                hit_nxt  = 1'b1;
                edge_nxt = (vcount == game_pkg::LEDGE_VSTART[l]);  // Top row.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_hit    <= 1'b0;
            ledge_hit <= 1'b0;
        end else begin
            s1_hit    <= hit_nxt;
            ledge_hit <= s1_hit;
        end
    end

    always_ff @(posedge clk) begin
        s1_edge   <= edge_nxt;
        ledge_rgb <= s1_edge ? edge_color : game_pkg::LEDGE_COLOR;
    end

endmodule

`default_nettype wire

//--- hw/level_ctrl.sv
// Level selection over a four-phase req/ack handshake.
// The ramp and ledge masks switch only at frame start.
`timescale 1ns/1ns
`default_nettype none

module level_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic [10:0]       hcount,
    input  logic [10:0]       vcount,
    input  logic              lvl_req,
    input  game_pkg::level_e  lvl_code,
    output logic              lvl_ack,
    output logic [3:0]        ramp_mask,
    output logic [3:0]        ledge_mask
);

    game_pkg::lvl_state_e state;
    game_pkg::lvl_state_e state_nxt;
    logic                 frame_start;
    logic                 load;

    assign frame_start = (hcount == 11'd0) && (vcount == 11'd0);
    assign load        = (state_nxt == game_pkg::ACKED) && (state != game_pkg::ACKED);

    always_comb begin
        state_nxt = state;
        case (state)
            game_pkg::IDLE: begin
                // A request that lands on a frame start is served at once.
                if (lvl_req) begin
                    state_nxt = frame_start ? game_pkg::ACKED : game_pkg::PENDING;
                end
            end
            game_pkg::PENDING: begin
                if (frame_start) begin
                    state_nxt = game_pkg::ACKED;
                end
            end
            game_pkg::ACKED: begin
                if (!lvl_req) begin
                    state_nxt = game_pkg::IDLE;
                end
            end
            default: state_nxt = game_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= game_pkg::IDLE;
            lvl_ack    <= 1'b0;
            ramp_mask  <= '0;  // LEVEL_EMPTY.
            ledge_mask <= '0;
        end else begin
            state   <= state_nxt;
            lvl_ack <= (state_nxt == game_pkg::ACKED);
            if (load) begin
                ramp_mask  <= game_pkg::LEVEL_RAMP_MASK[lvl_code];
                ledge_mask <= game_pkg::LEVEL_LEDGE_MASK[lvl_code];
            end
        end
    end

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(lvl_ack) |-> $past(lvl_req));

    // A mask change must follow a cycle that showed the frame start.
    masks_at_frame_start: assert property (@(posedge clk) disable iff (rst)
        (!$past(rst) && (!$stable(ramp_mask) || !$stable(ledge_mask)))
            |-> $past(frame_start));

endmodule

`default_nettype wire

//--- hw/platform_top.sv
// Top level of the platform renderer.
// Timing generator, level control, both renderers and the layer mixer.
`timescale 1ns/1ns
`default_nettype none

module platform_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              game_en,
    input  logic              lvl_req,
    input  game_pkg::level_e  lvl_code,
    output logic              lvl_ack,
    output logic [10:0]       hcount,
    output logic [10:0]       vcount,
    output logic              hsync,
    output logic              vsync,
    output logic [11:0]       rgb
);

    logic [10:0] tim_hcount;
    logic [10:0] tim_vcount;
    logic        tim_hsync;
    logic        tim_vsync;
    logic        tim_blank;
    logic [3:0]  ramp_mask;
    logic [3:0]  ledge_mask;
    logic        ramp_hit;
    logic        ledge_hit;
    logic [11:0] ramp_rgb;
    logic [11:0] ledge_rgb;

    vga_timing vga_timing_i (
        .clk, .rst,
        .hcount (tim_hcount),
        .vcount (tim_vcount),
        .hsync  (tim_hsync),
        .vsync  (tim_vsync),
        .blank  (tim_blank)
    );

    level_ctrl level_ctrl_i (
        .clk, .rst,
        .hcount (tim_hcount),
        .vcount (tim_vcount),
        .lvl_req, .lvl_code, .lvl_ack,
        .ramp_mask, .ledge_mask
    );

    ramp_draw ramp_draw_i (
        .clk, .rst,
        .hcount (tim_hcount),
        .vcount (tim_vcount),
        .ramp_mask, .ramp_hit, .ramp_rgb
    );

    ledge_draw ledge_draw_i (
        .clk, .rst,
        .hcount (tim_hcount),
        .vcount (tim_vcount),
        .ledge_mask, .ledge_hit, .ledge_rgb
    );

    // Outputs leave three clocks behind the timing counters.
    layer_mix layer_mix_i (
        .clk, .rst, .game_en,
        .hcount     (tim_hcount),
        .vcount     (tim_vcount),
        .hsync      (tim_hsync),
        .vsync      (tim_vsync),
        .blank      (tim_blank),
        .ramp_hit, .ledge_hit, .ramp_rgb, .ledge_rgb,
        .out_hcount (hcount),
        .out_vcount (vcount),
        .out_hsync  (hsync),
        .out_vsync  (vsync),
        .rgb
    );

endmodule

`default_nettype wire

//--- hw/ramp_draw.sv
// Inclined staircase renderer with a checker texture per block.
// Two pipeline stages from the counters to hit and colour.
`timescale 1ns/1ns
`default_nettype none

module ramp_draw (
    input  logic        clk,
    input  logic        rst,
    input  logic [10:0] hcount,
    input  logic [10:0] vcount,
    input  logic [3:0]  ramp_mask,
    output logic        ramp_hit,
    output logic [11:0] ramp_rgb
);

    logic hit_nxt;
    logic tex_x_nxt;
    logic tex_y_nxt;
    logic s1_hit;
    logic s1_tex_x;
    logic s1_tex_y;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage 1: block test and block-local position.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        logic [10:0] left;
        logic [10:0] top;
        logic [10:0] local_x;
        logic [10:0] local_y;

        hit_nxt   = 1'b0;
        tex_x_nxt = 1'b0;
        tex_y_nxt = 1'b0;
        // Highest ramp first, so the lowest-numbered one is written last and wins.
        for (int r = game_pkg::RAMP_COUNT - 1; r >= 0; r--) begin
            for (int i = 0; i < game_pkg::MAX_STEPS; i++) begin
                left = game_pkg::RAMP_HSTART[r] + 11'(i * game_pkg::BLOCK_WIDTH);
                if (game_pkg::RAMP_RISING[r]) begin
                    top = game_pkg::RAMP_VSTART[r] - 11'(i * game_pkg::STEP_OFFSET);
                end else begin
                    top = game_pkg::RAMP_VSTART[r] + 11'(i * game_pkg::STEP_OFFSET);
                end
                local_x = hcount - left;
                local_y = vcount - top;
                if (ramp_mask[r] && (i < game_pkg::RAMP_STEPS[r]) &&
                    (hcount >= left) && (hcount < left + 11'(game_pkg::BLOCK_WIDTH)) &&
                    (vcount >= top) && (vcount < top + 11'(game_pkg::BLOCK_HEIGHT))) begin
                    hit_nxt   = 1'b1;
                    tex_x_nxt = local_x[3];
                    tex_y_nxt = local_y[2];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_hit <= 1'b0;
        end else begin
            s1_hit <= hit_nxt;
        end
    end

    always_ff @(posedge clk) begin
        s1_tex_x <= tex_x_nxt;
        s1_tex_y <= tex_y_nxt;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage 2: hit and checker colour.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            ramp_hit <= 1'b0;
        end else begin
            ramp_hit <= s1_hit;
        end
    end

    always_ff @(posedge clk) begin
        ramp_rgb <= (s1_tex_x == s1_tex_y) ? game_pkg::RAMP_COLOR_A
                                           : game_pkg::RAMP_COLOR_B;
    end

    no_hit_without_mask: assert property (@(posedge clk) disable iff (rst)
        ($past(ramp_mask, 2) == 4'd0) |-> !ramp_hit);

endmodule

`default_nettype wire

//--- hw/vga_timing.sv
// Pixel counters, sync pulses and blanking for 640x480.
`timescale 1ns/1ns
`default_nettype none

module vga_timing (
    input  logic        clk,
    input  logic        rst,
    output logic [10:0] hcount,
    output logic [10:0] vcount,
    output logic        hsync,
    output logic        vsync,
    output logic        blank
);

    logic [10:0] hcount_nxt;
    logic [10:0] vcount_nxt;

    always_comb begin
        hcount_nxt = hcount + 11'd1;
        vcount_nxt = vcount;
        if (hcount == game_pkg::H_TOTAL - 11'd1) begin
            hcount_nxt = '0;
            if (vcount == game_pkg::V_TOTAL - 11'd1) begin
                vcount_nxt = '0;
            end else begin
                vcount_nxt = vcount + 11'd1;
            end
        end
    end

    // Syncs and blanking are decoded from the next count so they line up with it.
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b1;
            vsync  <= 1'b1;
            blank  <= 1'b0;
        end else begin
            hcount <= hcount_nxt;
            vcount <= vcount_nxt;
            hsync  <= !((hcount_nxt >= game_pkg::H_ACTIVE + game_pkg::H_FRONT) &&
                        (hcount_nxt <  game_pkg::H_ACTIVE + game_pkg::H_FRONT +
                                       game_pkg::H_SYNC));
            vsync  <= !((vcount_nxt >= game_pkg::V_ACTIVE + game_pkg::V_FRONT) &&
                        (vcount_nxt <  game_pkg::V_ACTIVE + game_pkg::V_FRONT +
                                       game_pkg::V_SYNC));
            blank  <= (hcount_nxt >= game_pkg::H_ACTIVE) ||
                      (vcount_nxt >= game_pkg::V_ACTIVE);  // Outside the visible area.
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Builds the platform renderer testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f verilog.f --top-module platform_tb \
        --Mdir obj_dir -o platform_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! sim_out=$(./obj_dir/platform_sim); then
    printf '%s\n' "$sim_out"
    echo "Simulation exited with an error"
    exit 1
fi
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -q "^RESULT: PASS$"; then
    exit 0
fi
exit 1

//--- verilog.f
hw/game_pkg.sv
hw/vga_timing.sv
hw/level_ctrl.sv
hw/ramp_draw.sv
hw/ledge_draw.sv
hw/layer_mix.sv
hw/platform_top.sv
bench/platform_tb.sv
